// File: Makefile
# Verilator build and run for the vector coprocessor testbench

TOP := tb_vec_top
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

# The run passes only if the log holds the pass line
run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
src/vec_pkg.sv
src/vec_req_if.sv
src/vec_vrf_if.sv
src/vec_decoder.sv
src/vec_vfu.sv
src/vec_vrf.sv
src/vec_result.sv
src/vec_top.sv
sim/tb_vec_top.sv

// File: sim/tb_vec_top.sv
////////////////////////////////////////////////////////////////////////////
// Vector coprocessor testbench
// Random issue stream from an LFSR, reference model of the register
// file, result checking under back-pressure and a watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_vec_top;

  import vec_pkg::*;

  // Test lengths in issued instructions
  localparam int N_READ  = NR_VREGS * N_LANES;
  localparam int N_WRAP  = 3;
  localparam int N_ARITH = 60;
  localparam int N_HAZ   = 30;
  localparam int N_BP    = 40;
  localparam int N_ILL   = 16;
  localparam int N_TOTAL = 6 * N_READ + NR_VREGS + N_WRAP + N_ARITH + 2 * N_HAZ +
                           N_BP + N_ILL;
  localparam int WATCHDOG_CYCLES = 20 * N_TOTAL + 200;

  logic                clk;
  logic                rst_n_i;
  logic                x_issue_valid_i;
  logic [OP_W-1:0]     x_issue_op_i;
  logic [VREG_AW-1:0]  x_issue_vd_i;
  logic [VREG_AW-1:0]  x_issue_vs1_i;
  logic [VREG_AW-1:0]  x_issue_vs2_i;
  logic [ELEN-1:0]     x_issue_scalar_i;
  logic                x_issue_ready_o;
  logic                x_issue_illegal_o;
  logic                x_result_valid_o;
  logic                x_result_ready_i;
  logic [ELEN-1:0]     x_result_data_o;

  logic [31:0]         lfsr_state;
  logic [ELEN-1:0]     model_v [NR_VREGS][N_LANES];
  logic [ELEN-1:0]     exp_q [$];
  logic                bp_en;
  string               test_name;
  int                  errors;
  int                  checks;

  vec_top vec_top_i (
    .clk_i            (clk),
    .rst_n_i          (rst_n_i),
    .x_issue_valid_i  (x_issue_valid_i),
    .x_issue_op_i     (x_issue_op_i),
    .x_issue_vd_i     (x_issue_vd_i),
    .x_issue_vs1_i    (x_issue_vs1_i),
    .x_issue_vs2_i    (x_issue_vs2_i),
    .x_issue_scalar_i (x_issue_scalar_i),
    .x_issue_ready_o  (x_issue_ready_o),
    .x_issue_illegal_o(x_issue_illegal_o),
    .x_result_valid_o (x_result_valid_o),
    .x_result_ready_i (x_result_ready_i),
    .x_result_data_o  (x_result_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////////
  // Random bits and reference model
  //////////////////////////////////////////////////////////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // vs2 is the first operand, vsub gives vs2 - vs1
  task automatic model_apply(input logic [OP_W-1:0] op, input logic [VREG_AW-1:0] vd,
                             input logic [VREG_AW-1:0] vs1,
                             input logic [VREG_AW-1:0] vs2, input logic [ELEN-1:0] scalar);
    logic [ELEN-1:0] res [N_LANES];
    if (op == OP_VMV_X_S) begin
      exp_q.push_back(model_v[vs2][scalar[1:0]]);
    end else if (op < OP_VMV_X_S) begin
      for (int l = 0; l < N_LANES; l++) begin
        case (op)
          OP_VADD_VV: res[l] = model_v[vs2][l] + model_v[vs1][l];
          OP_VSUB_VV: res[l] = model_v[vs2][l] - model_v[vs1][l];
          OP_VAND_VV: res[l] = model_v[vs2][l] & model_v[vs1][l];
          OP_VOR_VV:  res[l] = model_v[vs2][l] | model_v[vs1][l];
          OP_VXOR_VV: res[l] = model_v[vs2][l] ^ model_v[vs1][l];
          OP_VADD_VX: res[l] = model_v[vs2][l] + scalar;
          default:    res[l] = scalar;
        endcase
      end
      for (int l = 0; l < N_LANES; l++) begin
        model_v[vd][l] = res[l];
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Issue side
  //////////////////////////////////////////////////////////////////////////

  // Called at 2 ns after a rising edge, returns at the same point
  task automatic issue(input logic [OP_W-1:0] op, input logic [VREG_AW-1:0] vd,
                       input logic [VREG_AW-1:0] vs1, input logic [VREG_AW-1:0] vs2,
                       input logic [ELEN-1:0] scalar);
    logic rdy;
    logic ill;
    x_issue_valid_i  = 1'b1;
    x_issue_op_i     = op;
    x_issue_vd_i     = vd;
    x_issue_vs1_i    = vs1;
    x_issue_vs2_i    = vs2;
    x_issue_scalar_i = scalar;
    rdy = 1'b0;
    ill = 1'b0;
    while (!rdy) begin
      @(negedge clk);
      rdy = x_issue_ready_o;
      ill = x_issue_illegal_o;
      @(posedge clk);
      #2;
    end
    x_issue_valid_i = 1'b0;
    checks++;
    assert (ill == (op >= 4'd8)) else begin
      $display("ERR %s illegal flag for op %0d expected %0b actual %0b",
               test_name, op, op >= 4'd8, ill);
      errors++;
    end
    model_apply(op, vd, vs1, vs2, scalar);
  endtask

  task automatic issue_random_operands(input logic [OP_W-1:0] op);
    logic [31:0] vd;
    logic [31:0] vs1;
    logic [31:0] vs2;
    logic [31:0] scalar;
    draw(VREG_AW, vd);
    draw(VREG_AW, vs1);
    draw(VREG_AW, vs2);
    draw(ELEN, scalar);
    issue(op, vd[2:0], vs1[2:0], vs2[2:0], scalar);
  endtask

  // Element move of every element of every register
  task automatic readback_all();
    for (int r = 0; r < NR_VREGS; r++) begin
      for (int e = 0; e < N_LANES; e++) begin
        issue(OP_VMV_X_S, 3'd0, 3'd0, r[2:0], e);
      end
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #2;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Result side, ready changes after the edge, sampled mid-cycle
  //////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]     v;
    logic            rdy_next;
    logic [ELEN-1:0] exp;
    x_result_ready_i = 1'b0;
    rdy_next = 1'b1;
    @(posedge rst_n_i);
    forever begin
      @(posedge clk);
      #2;
      x_result_ready_i = rdy_next;
      @(negedge clk);
      if (x_result_valid_o && x_result_ready_i) begin
        checks++;
        assert (exp_q.size() != 0) else begin
          $display("Result %08h arrived in test %s with no element move pending",
                   x_result_data_o, test_name);
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          assert (x_result_data_o == exp) else begin
            $display("ERR %s result expected %08h actual %08h",
                     test_name, exp, x_result_data_o);
            errors++;
          end
        end
      end
      if (bp_en) begin
        draw(1, v);
        rdy_next = v[0];
      end else begin
        rdy_next = 1'b1;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the DUT stopped taking or returning work",
             WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]        v;
    logic [31:0]        w;
    logic [31:0]        u;
    logic [VREG_AW-1:0] prev_vd;
    lfsr_state       = 32'h3614;
    errors           = 0;
    checks           = 0;
    bp_en            = 1'b0;
    test_name        = "reset";
    rst_n_i          = 1'b0;
    x_issue_valid_i  = 1'b0;
    x_issue_op_i     = '0;
    x_issue_vd_i     = '0;
    x_issue_vs1_i    = '0;
    x_issue_vs2_i    = '0;
    x_issue_scalar_i = '0;
    for (int r = 0; r < NR_VREGS; r++) begin
      for (int l = 0; l < N_LANES; l++) begin
        model_v[r][l] = '0;
      end
    end
    repeat (10) @(posedge clk);
    #2;
    rst_n_i = 1'b1;

    @(negedge clk);
    checks += 2;
    assert (x_result_valid_o === 1'b0) else begin
      $display("ERR %s result valid expected 0 actual %b", test_name, x_result_valid_o);
      errors++;
    end
    assert (x_issue_ready_o === 1'b1) else begin
      $display("ERR %s issue ready expected 1 actual %b", test_name, x_issue_ready_o);
      errors++;
    end
    @(posedge clk);
    #2;
    readback_all();
    drain();

    test_name = "broadcast";
    for (int r = 0; r < NR_VREGS; r++) begin
      draw(ELEN, v);
      issue(OP_VMV_V_X, r[2:0], 3'd0, 3'd0, v);
    end
    readback_all();
    drain();

    // Fixed wraparound cases first, then the random mix
    test_name = "arith";
    issue(OP_VMV_V_X, 3'd0, 3'd0, 3'd0, 32'hffff_fff0);
    issue(OP_VADD_VX, 3'd1, 3'd0, 3'd0, 32'h0000_0020);
    issue(OP_VADD_VV, 3'd2, 3'd0, 3'd0, 32'h0);
    for (int i = 0; i < N_ARITH; i++) begin
      draw(3, v);
      issue_random_operands({1'b0, v[2:0] % 3'd6});
    end
    readback_all();
    drain();

    test_name = "hazard";
    prev_vd = 3'd2;
    for (int i = 0; i < N_HAZ; i++) begin
      draw(VREG_AW, w);
      draw(ELEN, v);
      issue(OP_VADD_VX, w[2:0], prev_vd, prev_vd, v);
      prev_vd = w[2:0];
    end
    // Chained vs2 against a random vs1
    for (int i = 0; i < N_HAZ; i++) begin
      draw(3, v);
      draw(VREG_AW, w);
      draw(VREG_AW, u);
      issue({1'b0, v[2:0] % 3'd5}, w[2:0], u[2:0], prev_vd, 32'h0);
      prev_vd = w[2:0];
    end
    readback_all();
    drain();

    test_name = "backpressure";
    bp_en = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      draw(3, v);
      issue_random_operands({1'b0, v[2:0]});
    end
    readback_all();
    drain();
    bp_en = 1'b0;

    test_name = "illegal";
    for (int i = 0; i < N_ILL; i++) begin
      draw(3, v);
      issue_random_operands({1'b1, v[2:0]});
    end
    readback_all();
    drain();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_vec_top

// File: src/vec_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Vector instruction decoder
// Accepts issue requests, flags illegal opcodes, blocks on scoreboard
// hazards and holds one decoded request for the execute pipeline
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_decoder (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Issue from the core
  input  logic                         issue_valid_i,
  input  vec_pkg::vec_op_e             issue_op_i,
  input  logic [vec_pkg::VREG_AW-1:0]  issue_vd_i,
  input  logic [vec_pkg::VREG_AW-1:0]  issue_vs1_i,
  input  logic [vec_pkg::VREG_AW-1:0]  issue_vs2_i,
  input  logic [vec_pkg::ELEN-1:0]     issue_scalar_i,
  output logic                         issue_ready_o,
  output logic                         issue_illegal_o,
  // Towards the VFU
  vec_req_if.dec                       req,
  vec_vrf_if.sb                        wb
);

  import vec_pkg::*;

  logic [NR_VREGS-1:0] busy;
  logic [NR_VREGS-1:0] busy_set;
  logic [NR_VREGS-1:0] busy_clr;
  logic                uses_vs1;
  logic                writes_vd;
  logic                hazard;
  logic                req_free;
  logic                accept;
  logic                req_valid_q;
  vec_req_t            req_q;

  //////////////////////////////////////////////////////////////////////////
  // Legality and hazard check
  //////////////////////////////////////////////////////////////////////////

  assign issue_illegal_o = issue_op_i > OP_VMV_X_S;

  // Scalar-source ops skip vs1, the element move never writes vd
  assign uses_vs1  = issue_op_i inside {OP_VADD_VV, OP_VSUB_VV, OP_VAND_VV,
                                        OP_VOR_VV, OP_VXOR_VV};
  assign writes_vd = issue_op_i != OP_VMV_X_S;
  assign hazard    = busy[issue_vs2_i] || (uses_vs1 && busy[issue_vs1_i]) ||
                     (writes_vd && busy[issue_vd_i]);

  assign req_free      = !req_valid_q || req.ready;
  assign issue_ready_o = req_free && (issue_illegal_o || !hazard);
  assign accept        = issue_valid_i && issue_ready_o && !issue_illegal_o;

  //////////////////////////////////////////////////////////////////////////
  // Scoreboard
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    busy_set = '0;
    busy_clr = '0;
    if (accept && writes_vd) begin
      busy_set[issue_vd_i] = 1'b1;
    end
    if (wb.we) begin
      busy_clr[wb.waddr] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy <= '0;
    end else begin
      busy <= (busy & ~busy_clr) | busy_set;
    end
  end

  // Request register
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_valid_q <= 1'b0;
    end else if (accept) begin
      req_valid_q <= 1'b1;
    end else if (req.ready) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= '{op: issue_op_i, vd: issue_vd_i, vs1: issue_vs1_i,
                 vs2: issue_vs2_i, scalar: issue_scalar_i};
    end
  end

  assign req.valid = req_valid_q;
  assign req.req   = req_q;

  // Stalled request must not change under the VFU
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req.valid && !req.ready |=> req.valid && $stable(req.req));

  // Every write retires a register that was marked in flight
  a_clr_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb.we |-> busy[wb.waddr]);

endmodule : vec_decoder

// File: src/vec_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Vector coprocessor package
// Sizes of the register file and lanes, the opcode set and the decoded
// request that travels from the decoder to the execute pipeline
////////////////////////////////////////////////////////////////////////////

package vec_pkg;

  // Register file geometry
  localparam int unsigned NR_VREGS = 8;
  localparam int unsigned VREG_AW  = $clog2(NR_VREGS);

  // Fixed vector shape, four 32-bit elements
  localparam int unsigned N_LANES = 4;
  localparam int unsigned LANE_AW = $clog2(N_LANES);
  localparam int unsigned ELEN    = 32;
  localparam int unsigned VREG_W  = N_LANES * ELEN;

  // Result queue towards the core
  localparam int unsigned RES_DEPTH = 2;
  localparam int unsigned RES_PTR_W = $clog2(RES_DEPTH);
  localparam int unsigned RES_CNT_W = $clog2(RES_DEPTH + 1);

  localparam int unsigned OP_W = 4;

  // Codes 8 to 15 are illegal
  typedef enum logic [OP_W-1:0] {
    OP_VADD_VV = 4'd0,
    OP_VSUB_VV = 4'd1,
    OP_VAND_VV = 4'd2,
    OP_VOR_VV  = 4'd3,
    OP_VXOR_VV = 4'd4,
    OP_VADD_VX = 4'd5,
    OP_VMV_V_X = 4'd6,
    OP_VMV_X_S = 4'd7
  } vec_op_e;

  // Decoded request
  typedef struct packed {
    vec_op_e            op;
    logic [VREG_AW-1:0] vd;
    logic [VREG_AW-1:0] vs1;
    logic [VREG_AW-1:0] vs2;
    logic [ELEN-1:0]    scalar;
  } vec_req_t;

endpackage : vec_pkg

// File: src/vec_req_if.sv
////////////////////////////////////////////////////////////////////////////
// Decoded request channel
// Valid/ready handshake from the decoder into the execute pipeline
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface vec_req_if;

  import vec_pkg::*;

  logic     valid;
  logic     ready;
  vec_req_t req;

  // Decoder side, holds valid and req until ready
  modport dec (
    output valid,
    output req,
    input  ready
  );

  modport vfu (
    input  valid,
    input  req,
    output ready
  );

endinterface : vec_req_if

// File: src/vec_result.sv
////////////////////////////////////////////////////////////////////////////
// Result queue
// Small FIFO between the VFU element moves and the core result port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_result (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // From the VFU
  input  logic                     res_valid_i,
  output logic                     res_ready_o,
  input  logic [vec_pkg::ELEN-1:0] res_data_i,
  // To the core
  output logic                     x_result_valid_o,
  input  logic                     x_result_ready_i,
  output logic [vec_pkg::ELEN-1:0] x_result_data_o
);

  import vec_pkg::*;

  logic [ELEN-1:0]      mem_q [RES_DEPTH];
  logic [RES_PTR_W-1:0] wr_ptr_q;
  logic [RES_PTR_W-1:0] rd_ptr_q;
  logic [RES_CNT_W-1:0] count_q;
  logic                 push;
  logic                 pop;

  assign res_ready_o      = count_q != RES_CNT_W'(RES_DEPTH);
  assign x_result_valid_o = count_q != '0;
  assign x_result_data_o  = mem_q[rd_ptr_q];

  assign push = res_valid_i && res_ready_o;
  assign pop  = x_result_valid_o && x_result_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + RES_CNT_W'(push) - RES_CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= res_data_i;
    end
  end

  // No push into a full queue, the VFU keeps its element until space opens
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_i && !res_ready_o |=> res_valid_i && $stable(res_data_i));

endmodule : vec_result

// File: src/vec_top.sv
////////////////////////////////////////////////////////////////////////////
// Vector coprocessor top level
// Decoder, VFU, register file and result queue behind the core's
// issue and result handshakes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Issue
  input  logic                        x_issue_valid_i,
  input  logic [vec_pkg::OP_W-1:0]    x_issue_op_i,
  input  logic [vec_pkg::VREG_AW-1:0] x_issue_vd_i,
  input  logic [vec_pkg::VREG_AW-1:0] x_issue_vs1_i,
  input  logic [vec_pkg::VREG_AW-1:0] x_issue_vs2_i,
  input  logic [vec_pkg::ELEN-1:0]    x_issue_scalar_i,
  output logic                        x_issue_ready_o,
  output logic                        x_issue_illegal_o,
  // Result
  output logic                        x_result_valid_o,
  input  logic                        x_result_ready_i,
  output logic [vec_pkg::ELEN-1:0]    x_result_data_o
);

  import vec_pkg::*;

  vec_req_if req_if ();
  vec_vrf_if vrf_if ();

  logic            res_valid;
  logic            res_ready;
  logic [ELEN-1:0] res_data;

  vec_decoder i_decoder (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .issue_valid_i  (x_issue_valid_i),
    .issue_op_i     (vec_op_e'(x_issue_op_i)),
    .issue_vd_i     (x_issue_vd_i),
    .issue_vs1_i    (x_issue_vs1_i),
    .issue_vs2_i    (x_issue_vs2_i),
    .issue_scalar_i (x_issue_scalar_i),
    .issue_ready_o  (x_issue_ready_o),
    .issue_illegal_o(x_issue_illegal_o),
    .req            (req_if),
    .wb             (vrf_if)
  );

  vec_vfu i_vfu (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req        (req_if),
    .vrf        (vrf_if),
    .res_valid_o(res_valid),
    .res_ready_i(res_ready),
    .res_data_o (res_data)
  );

  vec_vrf i_vrf (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .vrf    (vrf_if)
  );

  vec_result i_result (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .res_valid_i     (res_valid),
    .res_ready_o     (res_ready),
    .res_data_i      (res_data),
    .x_result_valid_o(x_result_valid_o),
    .x_result_ready_i(x_result_ready_i),
    .x_result_data_o (x_result_data_o)
  );

endmodule : vec_top

// File: src/vec_vfu.sv
////////////////////////////////////////////////////////////////////////////
// Vector function unit
// Two-stage pipeline, operand read then lane-parallel compute, writing
// the register file or handing one element to the result queue
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_vfu (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  vec_req_if.vfu                   req,
  vec_vrf_if.vfu                   vrf,
  // Element moves to the result queue
  output logic                     res_valid_o,
  input  logic                     res_ready_i,
  output logic [vec_pkg::ELEN-1:0] res_data_o
);

  import vec_pkg::*;

  // Stage 1, registered operands
  logic                            s1_valid_q;
  vec_op_e                         s1_op_q;
  logic [VREG_AW-1:0]              s1_vd_q;
  logic [ELEN-1:0]                 s1_scalar_q;
  logic [N_LANES-1:0][ELEN-1:0]    s1_a_q;
  logic [N_LANES-1:0][ELEN-1:0]    s1_b_q;
  logic                            s1_ready;

  // Stage 2, registered result
  logic                            s2_valid_q;
  logic                            s2_wr_q;
  logic [VREG_AW-1:0]              s2_vd_q;
  logic [N_LANES-1:0][ELEN-1:0]    s2_data_q;
  logic [N_LANES-1:0][ELEN-1:0]    s2_data_d;
  logic                            s2_ready;

  // Stage 2 drains every cycle unless an element move is blocked
  assign s2_ready  = !s2_valid_q || s2_wr_q || res_ready_i;
  assign s1_ready  = !s1_valid_q || s2_ready;
  assign req.ready = s1_ready;

  assign vrf.raddr_a = req.req.vs1;
  assign vrf.raddr_b = req.req.vs2;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= req.valid;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req.valid && s1_ready) begin
      s1_op_q     <= req.req.op;
      s1_vd_q     <= req.req.vd;
      s1_scalar_q <= req.req.scalar;
      s1_a_q      <= vrf.rdata_a;
      s1_b_q      <= vrf.rdata_b;
    end
    if (s1_valid_q && s2_ready) begin
      s2_wr_q   <= s1_op_q != OP_VMV_X_S;
      s2_vd_q   <= s1_vd_q;
      s2_data_q <= s2_data_d;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Lane compute, vs2 is the first operand as in RVV
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    s2_data_d = '0;
    for (int l = 0; l < N_LANES; l++) begin
      unique case (s1_op_q)
        OP_VADD_VV: s2_data_d[l] = s1_b_q[l] + s1_a_q[l];
        OP_VSUB_VV: s2_data_d[l] = s1_b_q[l] - s1_a_q[l];
        OP_VAND_VV: s2_data_d[l] = s1_b_q[l] & s1_a_q[l];
        OP_VOR_VV:  s2_data_d[l] = s1_b_q[l] | s1_a_q[l];
        OP_VXOR_VV: s2_data_d[l] = s1_b_q[l] ^ s1_a_q[l];
        OP_VADD_VX: s2_data_d[l] = s1_b_q[l] + s1_scalar_q;
        OP_VMV_V_X: s2_data_d[l] = s1_scalar_q;
        default:    s2_data_d[l] = '0;
      endcase
    end
    // Element move lands in lane 0
    if (s1_op_q == OP_VMV_X_S) begin
      s2_data_d[0] = s1_b_q[s1_scalar_q[LANE_AW-1:0]];
    end
  end

  assign vrf.we    = s2_valid_q && s2_wr_q;
  assign vrf.waddr = s2_vd_q;
  assign vrf.wdata = s2_data_q;

  assign res_valid_o = s2_valid_q && !s2_wr_q;
  assign res_data_o  = s2_data_q[0];

  a_we_res_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(vrf.we && res_valid_o));

endmodule : vec_vfu

// File: src/vec_vrf.sv
////////////////////////////////////////////////////////////////////////////
// Vector register file
// Eight whole-vector registers, two combinational reads, one write
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_vrf (
  input  logic   clk_i,
  input  logic   rst_n_i,
  vec_vrf_if.vrf vrf
);

  import vec_pkg::*;

  logic [VREG_W-1:0] regs_q [NR_VREGS];

  // Architectural state, every register reads zero after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < NR_VREGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (vrf.we) begin
      regs_q[vrf.waddr] <= vrf.wdata;
    end
  end

  // Reads see the old value during a write to the same register
  assign vrf.rdata_a = regs_q[vrf.raddr_a];
  assign vrf.rdata_b = regs_q[vrf.raddr_b];

endmodule : vec_vrf

// File: src/vec_vrf_if.sv
////////////////////////////////////////////////////////////////////////////
// Vector register file port bundle
// Two combinational read ports, one write port and a write monitor
// used by the scoreboard to retire busy registers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface vec_vrf_if;

  import vec_pkg::*;

  logic [VREG_AW-1:0] raddr_a;
  logic [VREG_AW-1:0] raddr_b;
  logic [VREG_W-1:0]  rdata_a;
  logic [VREG_W-1:0]  rdata_b;
  logic               we;
  logic [VREG_AW-1:0] waddr;
  logic [VREG_W-1:0]  wdata;

  modport vfu (
    output raddr_a,
    output raddr_b,
    input  rdata_a,
    input  rdata_b,
    output we,
    output waddr,
    output wdata
  );

  modport vrf (
    input  raddr_a,
    input  raddr_b,
    output rdata_a,
    output rdata_b,
    input  we,
    input  waddr,
    input  wdata
  );

  // Write monitor
  modport sb (
    input we,
    input waddr
  );

endinterface : vec_vrf_if
